//--- hdl/core_shell_pkg.sv
//////////////////////////////
// Widths and cache geometry for the core shell
// Scrambling key and nonce reset values
// Payload and address types
//////////////////////////////
package core_shell_pkg;

  //////////////////////////////
  // Register file
  //////////////////////////////

  localparam int unsigned REG_W         = 32;
  localparam int unsigned REG_ADDR_W    = 5;
  localparam int unsigned REG_NUM_WORDS = 2 ** REG_ADDR_W;

  //////////////////////////////
  // Instruction cache banks
  //////////////////////////////

  localparam int unsigned IC_NUM_WAYS  = 2;
  localparam int unsigned IC_NUM_LINES = 16;
  localparam int unsigned IC_INDEX_W   = $clog2(IC_NUM_LINES);
  localparam int unsigned IC_TAG_W     = 22;
  localparam int unsigned IC_LINE_W    = 64;

  //////////////////////////////
  // Scrambling
  //////////////////////////////

  localparam int unsigned SCR_KEY_W   = 64;
  localparam int unsigned SCR_NONCE_W = 64;

  // Copies of the bank address needed to fill one key width
  localparam int unsigned SCR_ADDR_REP = SCR_KEY_W / IC_INDEX_W;

  // Values used until the provider hands out the first key
  localparam logic [SCR_KEY_W-1:0]   SCR_KEY_DEFAULT   = 64'h3c9e_51a7_0d84_e2f6;
  localparam logic [SCR_NONCE_W-1:0] SCR_NONCE_DEFAULT = 64'hb417_6ac0_92ed_357f;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_W-1:0]      reg_data_t;

  typedef logic [IC_INDEX_W-1:0]  ic_index_t;
  typedef logic [IC_TAG_W-1:0]    ic_tag_t;
  typedef logic [IC_LINE_W-1:0]   ic_line_t;
  typedef logic [IC_NUM_WAYS-1:0] ic_way_mask_t;

  typedef logic [SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [SCR_NONCE_W-1:0] scr_nonce_t;

endpackage

//--- hdl/ic_ram_if.sv
//////////////////////////////
// Request and read data bundle of one
// instruction cache bank group
//////////////////////////////
`timescale 1ns/1ps

interface ic_ram_if import core_shell_pkg::*; #(
  parameter type payload_t = logic
) ();

  // One request bit per way, shared command fields
  ic_way_mask_t req;
  logic         write;
  ic_index_t    addr;
  payload_t     wdata;

  // Each way fills its own slot
  payload_t     rdata [IC_NUM_WAYS];

  modport requester (
    output req, write, addr, wdata,
    input  rdata
  );

  modport bank (
    input  req, write, addr, wdata,
    output rdata
  );

endinterface

//--- hdl/core_sleep_ctrl.sv
//////////////////////////////
// Core busy register, wake sources
// and latch-based clock gate
//////////////////////////////
`timescale 1ns/1ps

module core_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic debug_req_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clock_en;
  logic en_latched;

  //////////////////////////////
  // Busy flag and wake logic
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= core_busy_i;
    end
  end

  // Wake sources act at once, busy one cycle late
  assign clock_en     = busy_q | debug_req_i | irq_pending_i | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////
  // Clock gate
  //////////////////////////////

  // Enable only changes while clk_i is low
  // so the high phase never gets chopped
  always_latch begin
    if (!clk_i) begin
      en_latched <= clock_en | test_en_i;
    end
  end

  // Test mode keeps the clock running but sleep status is untouched
  assign clk_gated_o = clk_i & en_latched;

endmodule

//--- hdl/register_file_ff.sv
//////////////////////////////
// Flip-flop register file, 2 read ports,
// 1 write port, hardwired zero register
//////////////////////////////
`timescale 1ns/1ps

module register_file_ff import core_shell_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Read ports
  input  reg_addr_t raddr_a_i,
  output reg_data_t rdata_a_o,
  input  reg_addr_t raddr_b_i,
  output reg_data_t rdata_b_o,

  // Write port
  input  reg_addr_t waddr_i,
  input  reg_data_t wdata_i,
  input  logic      we_i
);

  reg_data_t                  rf_q [REG_NUM_WORDS];
  logic [REG_NUM_WORDS-1:1]   we_dec;

  //////////////////////////////
  // Write decoder
  //////////////////////////////

  // One-hot, word 0 has no enable
  always_comb begin
    for (int unsigned i = 1; i < REG_NUM_WORDS; i++) begin
      we_dec[i] = we_i && (waddr_i == reg_addr_t'(i));
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////

  for (genvar i = 1; i < REG_NUM_WORDS; i++) begin : gen_words
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_q[i] <= wdata_i;
      end
    end
  end

  // x0 reads zero whatever was written
  assign rf_q[0] = '0;

  // Combinational read muxes
  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

endmodule

//--- hdl/scramble_key_ctrl.sv
//////////////////////////////
// Scrambling key and nonce registers
// Key request exchange with the provider
//////////////////////////////
`timescale 1ns/1ps

module scramble_key_ctrl import core_shell_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Cache side
  input  logic       key_req_i,
  output logic       key_valid_o,

  // Provider side
  input  logic       key_valid_i,
  input  scr_key_t   key_i,
  input  scr_nonce_t nonce_i,
  output logic       key_req_o,

  // Current key material for the banks
  output scr_key_t   key_o,
  output scr_nonce_t nonce_o
);

  logic       req_d, req_q;
  logic       valid_d, valid_q;
  scr_key_t   key_q;
  scr_nonce_t nonce_q;

  // Request stays up until the provider answers
  assign req_d = req_q ? ~key_valid_i : key_req_i;

  // Key goes invalid on a new request, valid again with the answer
  assign valid_d = req_q     ? key_valid_i :
                   key_req_i ? 1'b0        :
                               valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q   <= 1'b0;
      valid_q <= 1'b1;
    end else begin
      req_q   <= req_d;
      valid_q <= valid_d;
    end
  end

  // Capture key material on every provider answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= SCR_KEY_DEFAULT;
      nonce_q <= SCR_NONCE_DEFAULT;
    end else if (key_valid_i) begin
      key_q   <= key_i;
      nonce_q <= nonce_i;
    end
  end

  assign key_req_o   = req_q;
  assign key_valid_o = valid_q;
  assign key_o       = key_q;
  assign nonce_o     = nonce_q;

endmodule

//--- hdl/scr_ram_1p.sv
//////////////////////////////
// Single-port cache bank with keystream
// scrambling, serves one way of a group
//////////////////////////////
`timescale 1ns/1ps

module scr_ram_1p import core_shell_pkg::*; #(
  parameter type         payload_t = logic,
  parameter int unsigned WAY       = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Shared bank group bundle
  ic_ram_if.bank     ram,

  // Key material
  input  logic       key_valid_i,
  input  scr_key_t   key_i,
  input  scr_nonce_t nonce_i
);

  payload_t mem_q [IC_NUM_LINES];
  payload_t rdata_q;
  scr_key_t keystream_full;
  payload_t keystream;
  logic     access;

  //////////////////////////////
  // Keystream
  //////////////////////////////

  // Address repeated over the key width, then cut to the payload
  assign keystream_full = key_i ^ nonce_i ^ {SCR_ADDR_REP{ram.addr}};
  assign keystream      = payload_t'(keystream_full);

  // No access while the key is being replaced
  assign access = ram.req[WAY] & key_valid_i;

  //////////////////////////////
  // Storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (access && ram.write) begin
      mem_q[ram.addr] <= ram.wdata ^ keystream;
    end
  end

  // Read data holds until the next read of this way
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (access && !ram.write) begin
      rdata_q <= mem_q[ram.addr] ^ keystream;
    end
  end

  assign ram.rdata[WAY] = rdata_q;

endmodule

//--- hdl/core_shell_top.sv
//////////////////////////////
// Core shell top level, sleep control,
// register file, key manager, cache banks
//////////////////////////////
`timescale 1ns/1ps

module core_shell_top import core_shell_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         test_en_i,

  // Sleep control
  input  logic         core_busy_i,
  input  logic         debug_req_i,
  input  logic         irq_pending_i,
  input  logic         irq_nm_i,
  output logic         core_sleep_o,

  // Register file
  input  reg_addr_t    rf_raddr_a_i,
  input  reg_addr_t    rf_raddr_b_i,
  input  reg_addr_t    rf_waddr_i,
  input  reg_data_t    rf_wdata_i,
  input  logic         rf_we_i,
  output reg_data_t    rf_rdata_a_o,
  output reg_data_t    rf_rdata_b_o,

  // Scrambling key exchange
  input  logic         ic_scr_key_req_i,
  output logic         ic_scr_key_valid_o,
  input  logic         scramble_key_valid_i,
  input  scr_key_t     scramble_key_i,
  input  scr_nonce_t   scramble_nonce_i,
  output logic         scramble_req_o,

  // Tag banks
  input  ic_way_mask_t ic_tag_req_i,
  input  logic         ic_tag_write_i,
  input  ic_index_t    ic_tag_addr_i,
  input  ic_tag_t      ic_tag_wdata_i,
  output ic_tag_t      ic_tag_rdata_o [IC_NUM_WAYS],

  // Line banks
  input  ic_way_mask_t ic_data_req_i,
  input  logic         ic_data_write_i,
  input  ic_index_t    ic_data_addr_i,
  input  ic_line_t     ic_data_wdata_i,
  output ic_line_t     ic_data_rdata_o [IC_NUM_WAYS]
);

  logic       clk_gated;
  scr_key_t   scr_key;
  scr_nonce_t scr_nonce;

  //////////////////////////////
  // Sleep control
  //////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_en_i    (test_en_i),
    .core_busy_i  (core_busy_i),
    .debug_req_i  (debug_req_i),
    .irq_pending_i(irq_pending_i),
    .irq_nm_i     (irq_nm_i),
    .clk_gated_o  (clk_gated),
    .core_sleep_o (core_sleep_o)
  );

  // Register file sits behind the clock gate
  register_file_ff u_register_file (
    .clk_i    (clk_gated),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .rdata_a_o(rf_rdata_a_o),
    .raddr_b_i(rf_raddr_b_i),
    .rdata_b_o(rf_rdata_b_o),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .we_i     (rf_we_i)
  );

  //////////////////////////////
  // Scrambling key
  //////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .key_req_i  (ic_scr_key_req_i),
    .key_valid_o(ic_scr_key_valid_o),
    .key_valid_i(scramble_key_valid_i),
    .key_i      (scramble_key_i),
    .nonce_i    (scramble_nonce_i),
    .key_req_o  (scramble_req_o),
    .key_o      (scr_key),
    .nonce_o    (scr_nonce)
  );

  //////////////////////////////
  // Cache banks
  //////////////////////////////

  ic_ram_if #(.payload_t(ic_tag_t))  tag_ram_if ();
  ic_ram_if #(.payload_t(ic_line_t)) data_ram_if ();

  assign tag_ram_if.req    = ic_tag_req_i;
  assign tag_ram_if.write  = ic_tag_write_i;
  assign tag_ram_if.addr   = ic_tag_addr_i;
  assign tag_ram_if.wdata  = ic_tag_wdata_i;
  assign ic_tag_rdata_o    = tag_ram_if.rdata;

  assign data_ram_if.req   = ic_data_req_i;
  assign data_ram_if.write = ic_data_write_i;
  assign data_ram_if.addr  = ic_data_addr_i;
  assign data_ram_if.wdata = ic_data_wdata_i;
  assign ic_data_rdata_o   = data_ram_if.rdata;

  for (genvar way = 0; way < IC_NUM_WAYS; way++) begin : gen_ways
    scr_ram_1p #(
      .payload_t(ic_tag_t),
      .WAY      (way)
    ) u_tag_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .ram        (tag_ram_if.bank),
      .key_valid_i(ic_scr_key_valid_o),
      .key_i      (scr_key),
      .nonce_i    (scr_nonce)
    );

    scr_ram_1p #(
      .payload_t(ic_line_t),
      .WAY      (way)
    ) u_data_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .ram        (data_ram_if.bank),
      .key_valid_i(ic_scr_key_valid_o),
      .key_i      (scr_key),
      .nonce_i    (scr_nonce)
    );
  end

endmodule

//--- testbench/tb_clk_gen.sv
//////////////////////////////
// Testbench clock, 100 ns period,
// reset held for two cycles
//////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- testbench/tb_core_shell.sv
//////////////////////////////
// Directed testbench for the core shell
// Register file, sleep, key and cache models
//////////////////////////////
`timescale 1ns/1ps

module tb_core_shell import core_shell_pkg::*; ();

  localparam int unsigned WAIT_LIMIT = 20;

  // DUT connections named as the ports
  logic         clk_i, rst_ni, test_en_i, core_sleep_o;
  logic         core_busy_i, debug_req_i, irq_pending_i, irq_nm_i;
  reg_addr_t    rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i;
  reg_data_t    rf_wdata_i, rf_rdata_a_o, rf_rdata_b_o;
  logic         rf_we_i, ic_scr_key_req_i, ic_scr_key_valid_o;
  logic         scramble_key_valid_i, scramble_req_o;
  scr_key_t     scramble_key_i;
  scr_nonce_t   scramble_nonce_i;
  ic_way_mask_t ic_tag_req_i, ic_data_req_i;
  logic         ic_tag_write_i, ic_data_write_i;
  ic_index_t    ic_tag_addr_i, ic_data_addr_i;
  ic_tag_t      ic_tag_wdata_i;
  ic_line_t     ic_data_wdata_i;
  ic_tag_t      ic_tag_rdata_o [IC_NUM_WAYS];
  ic_line_t     ic_data_rdata_o [IC_NUM_WAYS];

  //////////////////////////////
  // Reference models
  //////////////////////////////

  // Bank index 0 is the tag group and 1 the line group
  reg_data_t   rf_m [REG_NUM_WORDS];
  logic [63:0] plain_m [2][IC_NUM_WAYS][IC_NUM_LINES];
  logic [63:0] wks_m [2][IC_NUM_WAYS][IC_NUM_LINES];
  bit          written_m [2][IC_NUM_WAYS][IC_NUM_LINES];
  logic [63:0] last_m [2][IC_NUM_WAYS];
  logic        key_valid_m;
  scr_key_t    cur_key;
  scr_nonce_t  cur_nonce;
  int unsigned check_count, err_count;

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  core_shell_top u_core_shell_top (.*);

  // Key XOR nonce XOR the address repeated over the key
  function automatic logic [63:0] keystream(scr_key_t key, scr_nonce_t nonce, ic_index_t a);
    logic [63:0] rep;
    for (int i = 0; i < SCR_KEY_W; i += IC_INDEX_W) begin
      rep[i +: IC_INDEX_W] = a;
    end
    return key ^ nonce ^ rep;
  endfunction

  function automatic logic [63:0] payload_mask(int bank);
    return (bank == 0) ? (64'd1 << IC_TAG_W) - 64'd1 : '1;
  endfunction

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic abort_run(string reason);
    $display("Run stopped: %s", reason);
    $display("Verification failed");
    $finish;
  endtask

  task automatic report_test(string name, int unsigned errs_before);
    $display("%-14s : %0d errors", name, err_count - errs_before);
  endtask

  //////////////////////////////
  // Bus helpers
  //////////////////////////////

  task automatic write_register(reg_addr_t a, reg_data_t d, bit lands);
    @(posedge clk_i);
    rf_we_i    <= 1'b1;
    rf_waddr_i <= a;
    rf_wdata_i <= d;
    @(posedge clk_i);
    rf_we_i <= 1'b0;
    if (lands && a != 0) begin
      rf_m[a] = d;
    end
  endtask

  task automatic check_registers(reg_addr_t a, reg_addr_t b);
    @(posedge clk_i);
    rf_raddr_a_i <= a;
    rf_raddr_b_i <= b;
    @(negedge clk_i);
    check_value("rf_rdata_a_o", rf_m[a], rf_rdata_a_o);
    check_value("rf_rdata_b_o", rf_m[b], rf_rdata_b_o);
  endtask

  // Cache side request pulse
  // Key goes invalid one cycle later
  task automatic key_request();
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b1;
    @(posedge clk_i);
    ic_scr_key_req_i <= 1'b0;
    key_valid_m = 1'b0;
    @(negedge clk_i);
    check_value("scramble_req_o", 1, scramble_req_o);
    check_value("ic_scr_key_valid_o", 0, ic_scr_key_valid_o);
  endtask

  // Provider answers after a delay
  task automatic key_answer(scr_key_t key, scr_nonce_t nonce, int unsigned delay);
    int unsigned n;
    for (n = 0; n < WAIT_LIMIT && scramble_req_o !== 1'b1; n++) begin
      @(negedge clk_i);
    end
    if (scramble_req_o !== 1'b1) begin
      err_count++;
      $display("Timeout at %0t: scramble_req_o was never raised", $time);
    end
    repeat (delay) begin
      @(negedge clk_i);
      check_value("scramble_req_o", 1, scramble_req_o);
      check_value("ic_scr_key_valid_o", 0, ic_scr_key_valid_o);
    end
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b1;
    scramble_key_i       <= key;
    scramble_nonce_i     <= nonce;
    @(posedge clk_i);
    scramble_key_valid_i <= 1'b0;
    key_valid_m = 1'b1;
    cur_key     = key;
    cur_nonce   = nonce;
    @(negedge clk_i);
    check_value("scramble_req_o", 0, scramble_req_o);
    check_value("ic_scr_key_valid_o", 1, ic_scr_key_valid_o);
  endtask

  task automatic access_bank(int bank, int way, bit wr, ic_index_t a, logic [63:0] d);
    @(posedge clk_i);
    if (bank == 0) begin
      ic_tag_req_i   <= ic_way_mask_t'(1 << way);
      ic_tag_write_i <= wr;
      ic_tag_addr_i  <= a;
      ic_tag_wdata_i <= ic_tag_t'(d);
    end else begin
      ic_data_req_i   <= ic_way_mask_t'(1 << way);
      ic_data_write_i <= wr;
      ic_data_addr_i  <= a;
      ic_data_wdata_i <= d;
    end
    @(posedge clk_i);
    ic_tag_req_i  <= '0;
    ic_data_req_i <= '0;
  endtask

  task automatic write_bank(int bank, int way, ic_index_t a, logic [63:0] d);
    access_bank(bank, way, 1'b1, a, d);
    // Writes without a valid key are dropped
    if (key_valid_m) begin
      plain_m[bank][way][a]   = d & payload_mask(bank);
      wks_m[bank][way][a]     = keystream(cur_key, cur_nonce, a) & payload_mask(bank);
      written_m[bank][way][a] = 1'b1;
    end
  endtask

  task automatic read_bank(int bank, int way, ic_index_t a);
    logic [63:0] ks;
    access_bank(bank, way, 1'b0, a, '0);
    if (key_valid_m) begin
      ks = keystream(cur_key, cur_nonce, a);
      last_m[bank][way] = (plain_m[bank][way][a] ^ wks_m[bank][way][a] ^ ks) & payload_mask(bank);
    end
    @(negedge clk_i);
    if (bank == 0) begin
      check_value("ic_tag_rdata_o", last_m[bank][way], 64'(ic_tag_rdata_o[way]));
    end else begin
      check_value("ic_data_rdata_o", last_m[bank][way], ic_data_rdata_o[way]);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_state_test();
    int unsigned errs;
    errs = err_count;
    @(negedge clk_i);
    check_value("scramble_req_o", 0, scramble_req_o);
    check_value("ic_scr_key_valid_o", 1, ic_scr_key_valid_o);
    check_value("core_sleep_o", 1, core_sleep_o);
    repeat (4) check_registers(reg_addr_t'($urandom), reg_addr_t'($urandom));
    report_test("reset state", errs);
  endtask

  task automatic regfile_test();
    int unsigned errs;
    errs = err_count;
    @(posedge clk_i);
    core_busy_i <= 1'b1;
    // Gate opens two edges after busy rises
    repeat (2) @(posedge clk_i);
    repeat (24) write_register(reg_addr_t'($urandom), $urandom, 1'b1);
    write_register('0, 32'hdead_beef, 1'b1);
    for (int i = 0; i < REG_NUM_WORDS; i++) begin
      check_registers(reg_addr_t'(i), reg_addr_t'(REG_NUM_WORDS - 1 - i));
    end
    report_test("register file", errs);
  endtask

  task automatic sleep_test();
    int unsigned errs;
    reg_addr_t   a;
    errs = err_count;
    a    = reg_addr_t'(1 + $urandom % (REG_NUM_WORDS - 1));
    @(posedge clk_i);
    core_busy_i <= 1'b0;
    @(negedge clk_i);
    check_value("core_sleep_o", 0, core_sleep_o);
    @(negedge clk_i);
    check_value("core_sleep_o", 1, core_sleep_o);
    write_register(a, $urandom, 1'b0);
    check_registers(a, a);
    // One wake source at a time
    for (int w = 0; w < 3; w++) begin
      @(posedge clk_i);
      debug_req_i   <= (w == 0);
      irq_pending_i <= (w == 1);
      irq_nm_i      <= (w == 2);
      @(negedge clk_i);
      check_value("core_sleep_o", 0, core_sleep_o);
      write_register(a, $urandom, 1'b1);
      check_registers(a, a);
      @(posedge clk_i);
      debug_req_i   <= 1'b0;
      irq_pending_i <= 1'b0;
      irq_nm_i      <= 1'b0;
    end
    @(posedge clk_i);
    test_en_i <= 1'b1;
    write_register(a, $urandom, 1'b1);
    @(negedge clk_i);
    check_value("core_sleep_o", 1, core_sleep_o);
    check_registers(a, a);
    @(posedge clk_i);
    test_en_i <= 1'b0;
    report_test("sleep", errs);
  endtask

  task automatic key_exchange_test();
    int unsigned errs;
    errs = err_count;
    key_request();
    key_answer({$urandom, $urandom}, {$urandom, $urandom}, 1 + $urandom % 5);
    report_test("key exchange", errs);
  endtask

  task automatic cache_bank_test();
    int unsigned errs;
    ic_index_t   a;
    errs = err_count;
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < IC_NUM_WAYS; w++) begin
        repeat (4) begin
          a = ic_index_t'($urandom);
          write_bank(b, w, a, {$urandom, $urandom});
          read_bank(b, w, a);
        end
      end
    end
    // Accesses during the exchange must not touch the banks
    key_request();
    write_bank(1, 1, a, {$urandom, $urandom});
    read_bank(1, 0, a);
    key_answer({$urandom, $urandom}, {$urandom, $urandom}, $urandom % 4);
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < IC_NUM_WAYS; w++) begin
        for (int i = 0; i < IC_NUM_LINES; i++) begin
          if (written_m[b][w][i]) begin
            read_bank(b, w, ic_index_t'(i));
          end
        end
      end
    end
    report_test("cache banks", errs);
  endtask

  initial begin
    int unsigned seed;
    int unsigned n;
    seed = 87;
    void'($urandom(seed));
    {test_en_i, core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
    {rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i, rf_wdata_i, rf_we_i} = '0;
    {ic_scr_key_req_i, scramble_key_valid_i, scramble_key_i, scramble_nonce_i} = '0;
    {ic_tag_req_i, ic_tag_write_i, ic_tag_addr_i, ic_tag_wdata_i} = '0;
    {ic_data_req_i, ic_data_write_i, ic_data_addr_i, ic_data_wdata_i} = '0;
    key_valid_m = 1'b1;
    cur_key     = SCR_KEY_DEFAULT;
    cur_nonce   = SCR_NONCE_DEFAULT;
    check_count = 0;
    err_count   = 0;
    for (int i = 0; i < REG_NUM_WORDS; i++) begin
      rf_m[i] = '0;
    end
    // Read data registers reset to zero
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < IC_NUM_WAYS; w++) begin
        last_m[b][w] = '0;
      end
    end
    for (n = 0; n < WAIT_LIMIT && rst_ni !== 1'b1; n++) begin
      @(posedge clk_i);
    end
    if (rst_ni !== 1'b1) begin
      abort_run("reset was never released");
    end else begin
      reset_state_test();
      regfile_test();
      sleep_test();
      key_exchange_test();
      cache_bank_test();
      $display("Checks: %0d run, %0d failed", check_count, err_count);
      if (err_count == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

//--- vlog.f
hdl/core_shell_pkg.sv
hdl/ic_ram_if.sv
hdl/core_sleep_ctrl.sv
hdl/register_file_ff.sv
hdl/scramble_key_ctrl.sv
hdl/scr_ram_1p.sv
hdl/core_shell_top.sv
testbench/tb_clk_gen.sv
testbench/tb_core_shell.sv

//--- Bender.yml
package:
  name: core_shell

sources:
  - files:
      - hdl/core_shell_pkg.sv
      - hdl/ic_ram_if.sv
      - hdl/core_sleep_ctrl.sv
      - hdl/register_file_ff.sv
      - hdl/scramble_key_ctrl.sv
      - hdl/scr_ram_1p.sv
      - hdl/core_shell_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_core_shell.sv
